// File: rtl/xbar_defines.svh
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// crossbar size
`define XBAR_MST_NB   3
`define XBAR_SLV_NB   3

// channel widths
`define XBAR_ADDR_W   32
`define XBAR_DATA_W   32
`define XBAR_LID_W    2
`define XBAR_TAG_W    2

// beats minus one
`define XBAR_LEN_W    4

// slave k owns the window starting at k times the span
`define XBAR_SLV_SPAN 4096

`endif

// File: rtl/xbar_pkg.sv
`include "xbar_defines.svh"

package xbar_pkg;

    // tag in the upper bits, local id below
    typedef struct packed {
        logic [`XBAR_TAG_W-1:0] tag;
        logic [`XBAR_LID_W-1:0] lid;
    } sid_fields_t;

    // slave-side id
    // the slave only echoes raw bits, the switch splits tag and local id
    typedef union packed {
        logic [`XBAR_TAG_W+`XBAR_LID_W-1:0] raw;
        sid_fields_t                         f;
    } sid_u;

    // master-side ar word
    typedef struct packed {
        logic [`XBAR_LID_W-1:0]  id;
        logic [`XBAR_ADDR_W-1:0] addr;
        logic [`XBAR_LEN_W-1:0]  len;
    } mst_ar_t;

    // slave-side ar word
    typedef struct packed {
        sid_u                    id;
        logic [`XBAR_ADDR_W-1:0] addr;
        logic [`XBAR_LEN_W-1:0]  len;
    } slv_ar_t;

    typedef struct packed {
        logic [`XBAR_LID_W-1:0]  id;
        logic [`XBAR_DATA_W-1:0] data;
        logic                    last;
    } mst_r_t;

    typedef struct packed {
        sid_u                    id;
        logic [`XBAR_DATA_W-1:0] data;
        logic                    last;
    } slv_r_t;

endpackage

// File: rtl/xbar_skid_stage.sv
`timescale 1ns/1ps

module xbar_skid_stage #(
    parameter int DATA_W = 32
) (
    input  logic              i_rst,
    input  logic              aclk,
    input  logic              i_valid,
    output logic              o_ready,
    input  logic [DATA_W-1:0] i_data,
    output logic              o_valid,
    input  logic              i_ready,
    output logic [DATA_W-1:0] o_data
);

    logic              skid_valid;
    logic [DATA_W-1:0] skid_data;
    logic              in_xfer;
    logic              main_free;

    // ready comes straight from a flop
    assign o_ready   = ~skid_valid;
    assign in_xfer   = i_valid & o_ready;
    // main register empty or draining this cycle
    assign main_free = ~o_valid | i_ready;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_free) begin
                if (skid_valid) begin
                    o_valid    <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    o_valid <= in_xfer;
                end
            end else if (in_xfer) begin
                // output stalled, park the word in flight
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (main_free) begin
            if (skid_valid) begin
                o_data <= skid_data;
            end else if (in_xfer) begin
                o_data <= i_data;
            end
        end
        if (in_xfer && !main_free) begin
            skid_data <= i_data;
        end
    end

endmodule

// File: rtl/xbar_mst_switch.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module xbar_mst_switch (
    input  logic                                      aclk,
    input  logic                                      i_rst,
    // from master-side stage
    input  logic                                      i_arvalid,
    output logic                                      o_arready,
    input  xbar_pkg::mst_ar_t                         i_ar,
    // toward slave switches
    output logic [`XBAR_SLV_NB-1:0]                   o_slv_arvalid,
    input  logic [`XBAR_SLV_NB-1:0]                   i_slv_arready,
    output xbar_pkg::mst_ar_t                         o_ar,
    input  logic [`XBAR_SLV_NB-1:0]                   i_slv_rvalid,
    output logic [`XBAR_SLV_NB-1:0]                   o_slv_rready,
    input  xbar_pkg::slv_r_t [`XBAR_SLV_NB-1:0]       i_slv_r,
    // back to master-side stage
    output logic                                      o_rvalid,
    input  logic                                      i_rready,
    output xbar_pkg::mst_r_t                          o_r
);

    logic [`XBAR_ADDR_W-1:0] win;
    logic [`XBAR_SLV_NB-1:0] dec_oh;
    logic [`XBAR_SLV_NB-1:0] busy_oh;
    logic                    busy;
    xbar_pkg::slv_r_t        r_sel;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign win = i_ar.addr / `XBAR_SLV_SPAN;

    for (genvar k = 0; k < `XBAR_SLV_NB; k++) begin : g_dec
        assign dec_oh[k] = (win == `XBAR_ADDR_W'(k));
    end

    assign busy = |busy_oh;

    // one burst in flight, so hold off while busy
    assign o_slv_arvalid = (i_arvalid && !busy) ? dec_oh : '0;
    assign o_arready     = ~busy & (|(dec_oh & i_slv_arready));
    assign o_ar          = i_ar;

    // remember the target until the last beat is back
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            busy_oh <= '0;
        end else if (i_arvalid && o_arready) begin
            busy_oh <= dec_oh;
        end else if (o_rvalid && i_rready && o_r.last) begin
            busy_oh <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read data gather
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        r_sel = '0;
        for (int k = 0; k < `XBAR_SLV_NB; k++) begin
            if (busy_oh[k]) begin
                r_sel = i_slv_r[k];
            end
        end
    end

    assign o_rvalid     = |(i_slv_rvalid & busy_oh);
    assign o_slv_rready = busy_oh & {`XBAR_SLV_NB{i_rready}};

    // drop the tag on the way back
    assign o_r.id   = r_sel.id.f.lid;
    assign o_r.data = r_sel.data;
    assign o_r.last = r_sel.last;

endmodule

// File: rtl/xbar_slv_switch.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module xbar_slv_switch (
    input  logic                                      aclk,
    input  logic                                      i_rst,
    // from master switches
    input  logic [`XBAR_MST_NB-1:0]                   i_mst_arvalid,
    output logic [`XBAR_MST_NB-1:0]                   o_mst_arready,
    input  xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0]      i_mst_ar,
    // toward slave-side stage
    output logic                                      o_arvalid,
    input  logic                                      i_arready,
    output xbar_pkg::slv_ar_t                         o_ar,
    input  logic                                      i_rvalid,
    output logic                                      o_rready,
    input  xbar_pkg::slv_r_t                          i_r,
    // back to master switches
    output logic [`XBAR_MST_NB-1:0]                   o_mst_rvalid,
    input  logic [`XBAR_MST_NB-1:0]                   i_mst_rready,
    output xbar_pkg::slv_r_t                          o_r
);

    logic [`XBAR_MST_NB-1:0] rr_ptr;
    logic [`XBAR_MST_NB-1:0] rr_gnt;
    logic [`XBAR_MST_NB-1:0] lock_gnt;
    logic                    locked;
    logic [`XBAR_MST_NB-1:0] gnt;
    logic [`XBAR_TAG_W-1:0]  tag;
    xbar_pkg::mst_ar_t       ar_sel;
    logic [`XBAR_MST_NB-1:0] r_dst;

    //////////////////////////////////////////////////////////////////////
    // round-robin ar arbitration
    //////////////////////////////////////////////////////////////////////

    // first requester at or after the pointer
    always_comb begin
        int unsigned base;
        base   = 0;
        rr_gnt = '0;
        for (int k = 0; k < `XBAR_MST_NB; k++) begin
            if (rr_ptr[k]) begin
                base = k;
            end
        end
        for (int n = 0; n < `XBAR_MST_NB; n++) begin
            if (rr_gnt == '0 && i_mst_arvalid[(base + n) % `XBAR_MST_NB]) begin
                rr_gnt[(base + n) % `XBAR_MST_NB] = 1'b1;
            end
        end
    end

    // keep the winner while the slave stalls
    assign gnt = locked ? lock_gnt : rr_gnt;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            rr_ptr   <= `XBAR_MST_NB'(1);
            locked   <= 1'b0;
            lock_gnt <= '0;
        end else if (o_arvalid && i_arready) begin
            locked <= 1'b0;
            // step past the winner
            rr_ptr <= {gnt[`XBAR_MST_NB-2:0], gnt[`XBAR_MST_NB-1]};
        end else if (o_arvalid) begin
            locked   <= 1'b1;
            lock_gnt <= gnt;
        end
    end

    always_comb begin
        ar_sel = '0;
        tag    = '0;
        for (int k = 0; k < `XBAR_MST_NB; k++) begin
            if (gnt[k]) begin
                ar_sel = i_mst_ar[k];
                tag    = `XBAR_TAG_W'(k + 1);
            end
        end
    end

    assign o_arvalid     = |(gnt & i_mst_arvalid);
    assign o_mst_arready = gnt & {`XBAR_MST_NB{i_arready}};

    assign o_ar.id.f.tag = tag;
    assign o_ar.id.f.lid = ar_sel.id;
    assign o_ar.addr     = ar_sel.addr;
    assign o_ar.len      = ar_sel.len;

    //////////////////////////////////////////////////////////////////////
    // r return by tag
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `XBAR_MST_NB; k++) begin : g_rdst
        assign r_dst[k] = (i_r.id.f.tag == `XBAR_TAG_W'(k + 1));
    end

    assign o_mst_rvalid = r_dst & {`XBAR_MST_NB{i_rvalid}};
    assign o_rready     = |(r_dst & i_mst_rready);
    assign o_r          = i_r;

endmodule

// File: rtl/axi_read_xbar_top.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module axi_read_xbar_top (
    input  logic                                      aclk,
    input  logic                                      i_rst,
    // master ports
    input  logic [`XBAR_MST_NB-1:0]                   i_m_arvalid,
    output logic [`XBAR_MST_NB-1:0]                   o_m_arready,
    input  xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0]      i_m_ar,
    output logic [`XBAR_MST_NB-1:0]                   o_m_rvalid,
    input  logic [`XBAR_MST_NB-1:0]                   i_m_rready,
    output xbar_pkg::mst_r_t [`XBAR_MST_NB-1:0]       o_m_r,
    // slave ports
    output logic [`XBAR_SLV_NB-1:0]                   o_s_arvalid,
    input  logic [`XBAR_SLV_NB-1:0]                   i_s_arready,
    output xbar_pkg::slv_ar_t [`XBAR_SLV_NB-1:0]      o_s_ar,
    input  logic [`XBAR_SLV_NB-1:0]                   i_s_rvalid,
    output logic [`XBAR_SLV_NB-1:0]                   o_s_rready,
    input  xbar_pkg::slv_r_t [`XBAR_SLV_NB-1:0]       i_s_r
);

    // master switch view, [mst][slv]
    logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_arvalid;
    logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_arready;
    logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_rvalid;
    logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_rready;
    // slave switch view, [slv][mst]
    logic [`XBAR_SLV_NB-1:0][`XBAR_MST_NB-1:0] s_arvalid;
    logic [`XBAR_SLV_NB-1:0][`XBAR_MST_NB-1:0] s_arready;
    logic [`XBAR_SLV_NB-1:0][`XBAR_MST_NB-1:0] s_rvalid;
    logic [`XBAR_SLV_NB-1:0][`XBAR_MST_NB-1:0] s_rready;

    xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0]      sw_ar;
    xbar_pkg::slv_r_t  [`XBAR_SLV_NB-1:0]      sw_r;

    //////////////////////////////////////////////////////////////////////
    // crossbar transpose
    //////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `XBAR_MST_NB; m++) begin : g_xm
        for (genvar s = 0; s < `XBAR_SLV_NB; s++) begin : g_xs
            assign s_arvalid[s][m] = m_arvalid[m][s];
            assign m_arready[m][s] = s_arready[s][m];
            assign m_rvalid[m][s]  = s_rvalid[s][m];
            assign s_rready[s][m]  = m_rready[m][s];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // master side
    //////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `XBAR_MST_NB; m++) begin : g_mst
        logic              pipe_arvalid;
        logic              pipe_arready;
        xbar_pkg::mst_ar_t pipe_ar;
        logic              pipe_rvalid;
        logic              pipe_rready;
        xbar_pkg::mst_r_t  pipe_r;

        xbar_skid_stage #(.DATA_W($bits(xbar_pkg::mst_ar_t))) u_ar_stage (
            .i_rst   (i_rst),
            .aclk    (aclk),
            .i_valid (i_m_arvalid[m]),
            .o_ready (o_m_arready[m]),
            .i_data  (i_m_ar[m]),
            .o_valid (pipe_arvalid),
            .i_ready (pipe_arready),
            .o_data  (pipe_ar)
        );

        xbar_skid_stage #(.DATA_W($bits(xbar_pkg::mst_r_t))) u_r_stage (
            .i_rst   (i_rst),
            .aclk    (aclk),
            .i_valid (pipe_rvalid),
            .o_ready (pipe_rready),
            .i_data  (pipe_r),
            .o_valid (o_m_rvalid[m]),
            .i_ready (i_m_rready[m]),
            .o_data  (o_m_r[m])
        );

        xbar_mst_switch u_mst_switch (
            .aclk          (aclk),
            .i_rst         (i_rst),
            .i_arvalid     (pipe_arvalid),
            .o_arready     (pipe_arready),
            .i_ar          (pipe_ar),
            .o_slv_arvalid (m_arvalid[m]),
            .i_slv_arready (m_arready[m]),
            .o_ar          (sw_ar[m]),
            .i_slv_rvalid  (m_rvalid[m]),
            .o_slv_rready  (m_rready[m]),
            .i_slv_r       (sw_r),
            .o_rvalid      (pipe_rvalid),
            .i_rready      (pipe_rready),
            .o_r           (pipe_r)
        );
    end

    //////////////////////////////////////////////////////////////////////
    // slave side
    //////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < `XBAR_SLV_NB; s++) begin : g_slv
        logic              pipe_arvalid;
        logic              pipe_arready;
        xbar_pkg::slv_ar_t pipe_ar;
        logic              pipe_rvalid;
        logic              pipe_rready;
        xbar_pkg::slv_r_t  pipe_r;

        xbar_slv_switch u_slv_switch (
            .aclk          (aclk),
            .i_rst         (i_rst),
            .i_mst_arvalid (s_arvalid[s]),
            .o_mst_arready (s_arready[s]),
            .i_mst_ar      (sw_ar),
            .o_arvalid     (pipe_arvalid),
            .i_arready     (pipe_arready),
            .o_ar          (pipe_ar),
            .i_rvalid      (pipe_rvalid),
            .o_rready      (pipe_rready),
            .i_r           (pipe_r),
            .o_mst_rvalid  (s_rvalid[s]),
            .i_mst_rready  (s_rready[s]),
            .o_r           (sw_r[s])
        );

        xbar_skid_stage #(.DATA_W($bits(xbar_pkg::slv_ar_t))) u_ar_stage (
            .i_rst   (i_rst),
            .aclk    (aclk),
            .i_valid (pipe_arvalid),
            .o_ready (pipe_arready),
            .i_data  (pipe_ar),
            .o_valid (o_s_arvalid[s]),
            .i_ready (i_s_arready[s]),
            .o_data  (o_s_ar[s])
        );

        xbar_skid_stage #(.DATA_W($bits(xbar_pkg::slv_r_t))) u_r_stage (
            .i_rst   (i_rst),
            .aclk    (aclk),
            .i_valid (i_s_rvalid[s]),
            .o_ready (o_s_rready[s]),
            .i_data  (i_s_r[s]),
            .o_valid (pipe_rvalid),
            .i_ready (pipe_rready),
            .o_data  (pipe_r)
        );
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // reset held for five rising edges
    initial begin
        o_rst = 1'b1;
        repeat (5) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tests/tb_scoreboard.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module tb_scoreboard (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic [`XBAR_MST_NB-1:0]              i_m_arvalid,
    input  logic [`XBAR_MST_NB-1:0]              i_m_arready,
    input  xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0] i_m_ar,
    input  logic [`XBAR_MST_NB-1:0]              i_m_rvalid,
    input  logic [`XBAR_MST_NB-1:0]              i_m_rready,
    input  xbar_pkg::mst_r_t [`XBAR_MST_NB-1:0]  i_m_r,
    input  logic [`XBAR_SLV_NB-1:0]              i_s_arvalid,
    input  logic [`XBAR_SLV_NB-1:0]              i_s_arready,
    input  xbar_pkg::slv_ar_t [`XBAR_SLV_NB-1:0] i_s_ar,
    output int                                   o_errors,
    output int                                   o_bursts
);

    xbar_pkg::mst_r_t  exp_q[`XBAR_MST_NB][$];
    // accepted master ARs not yet seen at a slave, oldest first
    xbar_pkg::mst_ar_t pend_q[`XBAR_MST_NB][$];
    int                errors = 0;
    int                bursts = 0;
    int                post_rst = 0;

    assign o_errors = errors;
    assign o_bursts = bursts;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // queue the beats a burst must return
    task automatic expect_burst(input int m, input xbar_pkg::mst_ar_t ar);
        xbar_pkg::mst_r_t beat;
        logic [31:0]      slv;
        slv = ar.addr / `XBAR_SLV_SPAN;
        for (int b = 0; b <= ar.len; b++) begin
            beat.id   = ar.id;
            beat.data = (ar.addr + 32'(4 * b)) ^ (slv << 28);
            beat.last = (b == ar.len);
            exp_q[m].push_back(beat);
        end
    endtask

    always @(posedge i_clk) begin
        xbar_pkg::mst_r_t  exp;
        xbar_pkg::mst_ar_t ar;
        int                m;
        if (i_rst || post_rst < 1) begin
            if (i_m_rvalid != '0 || i_s_arvalid != '0) begin
                errors++;
                $display("valid output raised during or right after reset");
            end
            post_rst = i_rst ? 0 : post_rst + 1;
        end
        if (!i_rst) begin
            for (int k = 0; k < `XBAR_MST_NB; k++) begin
                if (i_m_arvalid[k] && i_m_arready[k]) begin
                    pend_q[k].push_back(i_m_ar[k]);
                    expect_burst(k, i_m_ar[k]);
                end
                if (i_m_rvalid[k] && i_m_rready[k]) begin
                    if (exp_q[k].size() == 0) begin
                        errors++;
                        $display("master %0d received an R beat it never asked for", k);
                    end else begin
                        exp = exp_q[k].pop_front();
                        compare($sformatf("o_m_r[%0d].id", k), 32'(i_m_r[k].id), 32'(exp.id));
                        compare($sformatf("o_m_r[%0d].data", k), i_m_r[k].data, exp.data);
                        compare($sformatf("o_m_r[%0d].last", k), 32'(i_m_r[k].last),
                                32'(exp.last));
                        if (exp.last) begin
                            bursts++;
                        end
                    end
                end
            end
            for (int s = 0; s < `XBAR_SLV_NB; s++) begin
                if (i_s_arvalid[s] && i_s_arready[s]) begin
                    m = int'(i_s_ar[s].id.f.tag) - 1;
                    if (m < 0 || m >= `XBAR_MST_NB || pend_q[m].size() == 0) begin
                        errors++;
                        $display("slave %0d got an AR with tag %0d from no waiting master",
                                 s, i_s_ar[s].id.f.tag);
                    end else begin
                        ar = pend_q[m].pop_front();
                        compare($sformatf("o_s_ar[%0d].addr", s), i_s_ar[s].addr, ar.addr);
                        compare($sformatf("o_s_ar[%0d].len", s), 32'(i_s_ar[s].len),
                                32'(ar.len));
                        compare($sformatf("o_s_ar[%0d].id.lid", s), 32'(i_s_ar[s].id.f.lid),
                                32'(ar.id));
                        compare($sformatf("slave index of master %0d", m), 32'(s),
                                ar.addr / `XBAR_SLV_SPAN);
                    end
                end
            end
        end
    end

endmodule

// File: tests/xbar_checker.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module xbar_checker (
    input logic                                      aclk,
    input logic                                      i_rst,
    input logic [`XBAR_MST_NB-1:0]                   i_m_arvalid,
    input xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0]      i_m_ar,
    input logic [`XBAR_MST_NB-1:0]                   o_m_rvalid,
    input logic [`XBAR_MST_NB-1:0]                   i_m_rready,
    input xbar_pkg::mst_r_t [`XBAR_MST_NB-1:0]       o_m_r,
    input logic [`XBAR_SLV_NB-1:0]                   o_s_arvalid,
    input logic [`XBAR_SLV_NB-1:0]                   i_s_arready,
    input xbar_pkg::slv_ar_t [`XBAR_SLV_NB-1:0]      o_s_ar,
    input logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_arvalid,
    input logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_arready,
    input logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_rvalid,
    input logic [`XBAR_MST_NB-1:0][`XBAR_SLV_NB-1:0] m_rready,
    input xbar_pkg::slv_r_t [`XBAR_SLV_NB-1:0]       sw_r
);

    logic [`XBAR_MST_NB-1:0] ar_go;
    logic [`XBAR_MST_NB-1:0] r_end;
    logic [`XBAR_MST_NB-1:0] inflight;

    always_comb begin
        for (int m = 0; m < `XBAR_MST_NB; m++) begin
            ar_go[m] = |(m_arvalid[m] & m_arready[m]);
            r_end[m] = 1'b0;
            for (int s = 0; s < `XBAR_SLV_NB; s++) begin
                r_end[m] = r_end[m] | (m_rvalid[m][s] & m_rready[m][s] & sw_r[s].last);
            end
        end
    end

    // burst in flight between switch AR and last R beat
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            inflight <= '0;
        end else begin
            for (int m = 0; m < `XBAR_MST_NB; m++) begin
                if (ar_go[m]) begin
                    inflight[m] <= 1'b1;
                end else if (r_end[m]) begin
                    inflight[m] <= 1'b0;
                end
            end
        end
    end

    for (genvar m = 0; m < `XBAR_MST_NB; m++) begin : g_m
        a_single: assert property (@(posedge aclk) disable iff (i_rst)
            ar_go[m] |-> !inflight[m]) else $error("master %0d has two ARs in flight", m);
        a_in_map: assert property (@(posedge aclk) disable iff (i_rst)
            i_m_arvalid[m] |-> i_m_ar[m].addr < `XBAR_SLV_NB * `XBAR_SLV_SPAN)
            else $error("master %0d address outside the map", m);
        a_r_hold: assert property (@(posedge aclk) disable iff (i_rst)
            o_m_rvalid[m] && !i_m_rready[m] |=> o_m_rvalid[m] && $stable(o_m_r[m]))
            else $error("master %0d R dropped or changed before ready", m);
    end

    for (genvar s = 0; s < `XBAR_SLV_NB; s++) begin : g_s
        a_ar_hold: assert property (@(posedge aclk) disable iff (i_rst)
            o_s_arvalid[s] && !i_s_arready[s] |=> o_s_arvalid[s] && $stable(o_s_ar[s]))
            else $error("slave %0d AR dropped or changed before ready", s);
        a_window: assert property (@(posedge aclk) disable iff (i_rst)
            o_s_arvalid[s] |-> o_s_ar[s].addr / `XBAR_SLV_SPAN == s)
            else $error("slave %0d got an AR outside its window", s);
    end

endmodule

bind axi_read_xbar_top xbar_checker chk_i (
    .aclk        (aclk),
    .i_rst       (i_rst),
    .i_m_arvalid (i_m_arvalid),
    .i_m_ar      (i_m_ar),
    .o_m_rvalid  (o_m_rvalid),
    .i_m_rready  (i_m_rready),
    .o_m_r       (o_m_r),
    .o_s_arvalid (o_s_arvalid),
    .i_s_arready (i_s_arready),
    .o_s_ar      (o_s_ar),
    .m_arvalid   (m_arvalid),
    .m_arready   (m_arready),
    .m_rvalid    (m_rvalid),
    .m_rready    (m_rready),
    .sw_r        (sw_r)
);

// File: tests/tb_axi_read_xbar.sv
`timescale 1ns/1ps

`include "xbar_defines.svh"

module tb_axi_read_xbar;

    localparam int BURSTS_PER_TEST = 30;
    localparam int TIMEOUT_CYCLES  = 20000;

    logic                                 clk;
    logic                                 rst;
    logic [`XBAR_MST_NB-1:0]              m_arvalid;
    logic [`XBAR_MST_NB-1:0]              m_arready;
    xbar_pkg::mst_ar_t [`XBAR_MST_NB-1:0] m_ar;
    logic [`XBAR_MST_NB-1:0]              m_rvalid;
    logic [`XBAR_MST_NB-1:0]              m_rready;
    xbar_pkg::mst_r_t [`XBAR_MST_NB-1:0]  m_r;
    logic [`XBAR_SLV_NB-1:0]              s_arvalid;
    logic [`XBAR_SLV_NB-1:0]              s_arready;
    xbar_pkg::slv_ar_t [`XBAR_SLV_NB-1:0] s_ar;
    logic [`XBAR_SLV_NB-1:0]              s_rvalid;
    logic [`XBAR_SLV_NB-1:0]              s_rready;
    xbar_pkg::slv_r_t [`XBAR_SLV_NB-1:0]  s_r;
    int                                   errors;
    int                                   bursts;
    int                                   cycles = 0;
    int                                   err_before;

    tb_clock_gen clk_gen_i (.o_clk(clk), .o_rst(rst));

    axi_read_xbar_top dut_i (
        .aclk        (clk),
        .i_rst       (rst),
        .i_m_arvalid (m_arvalid),
        .o_m_arready (m_arready),
        .i_m_ar      (m_ar),
        .o_m_rvalid  (m_rvalid),
        .i_m_rready  (m_rready),
        .o_m_r       (m_r),
        .o_s_arvalid (s_arvalid),
        .i_s_arready (s_arready),
        .o_s_ar      (s_ar),
        .i_s_rvalid  (s_rvalid),
        .o_s_rready  (s_rready),
        .i_s_r       (s_r)
    );

    tb_scoreboard sb_i (
        .i_clk (clk), .i_rst (rst),
        .i_m_arvalid (m_arvalid), .i_m_arready (m_arready), .i_m_ar (m_ar),
        .i_m_rvalid (m_rvalid), .i_m_rready (m_rready), .i_m_r (m_r),
        .i_s_arvalid (s_arvalid), .i_s_arready (s_arready), .i_s_ar (s_ar),
        .o_errors (errors), .o_bursts (bursts)
    );

    ////////////////////////////////////////////////////////////////////
    // masters, test 0 spreads over all slaves, test 1 all hit slave 1
    ////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `XBAR_MST_NB; m++) begin : g_mst
        logic              arvalid = 1'b0;
        logic              rready  = 1'b0;
        xbar_pkg::mst_ar_t ar      = '0;
        int                n_done  = 0;

        assign m_arvalid[m] = arvalid;
        assign m_ar[m]      = ar;
        assign m_rready[m]  = rready;

        always @(negedge clk) begin
            rready = ($urandom % 4) != 0;
        end

        always @(posedge clk) begin
            if (!rst && m_rvalid[m] && m_rready[m] && m_r[m].last) begin
                n_done++;
            end
        end

        initial begin
            int slv;
            @(negedge clk);
            while (rst) @(negedge clk);
            for (int t = 0; t < 2; t++) begin
                // next AR follows right behind the accepted one
                for (int b = 0; b < BURSTS_PER_TEST; b++) begin
                    @(negedge clk);
                    slv     = (t == 0) ? int'($urandom % `XBAR_SLV_NB) : 1;
                    ar.addr = 32'(slv * `XBAR_SLV_SPAN) + (($urandom % 1024) * 4);
                    ar.len  = 4'($urandom % 8);
                    ar.id   = 2'($urandom % 4);
                    arvalid = 1'b1;
                    do @(posedge clk); while (!m_arready[m]);
                end
                @(negedge clk);
                arvalid = 1'b0;
                wait (n_done >= (t + 1) * BURSTS_PER_TEST);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // slave models
    ////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < `XBAR_SLV_NB; s++) begin : g_slv
        logic              arready = 1'b0;
        logic              rvalid  = 1'b0;
        xbar_pkg::slv_r_t  r       = '0;
        xbar_pkg::slv_ar_t req_q[$];
        int                beat    = 0;
        int                n_taken = 0;
        int                n_seen  = 0;

        assign s_arready[s] = arready;
        assign s_rvalid[s]  = rvalid;
        assign s_r[s]       = r;

        always @(posedge clk) begin
            if (!rst) begin
                if (s_arvalid[s] && arready) begin
                    req_q.push_back(s_ar[s]);
                end
                if (rvalid && s_rready[s]) begin
                    n_taken++;
                    if (beat == int'(req_q[0].len)) begin
                        beat = 0;
                        void'(req_q.pop_front());
                    end else begin
                        beat++;
                    end
                end
            end
        end

        always @(negedge clk) begin
            arready = ($urandom % 4) != 0;
            // a beat on the bus stays put until taken
            if (!rvalid || n_taken != n_seen) begin
                n_seen = n_taken;
                if (req_q.size() > 0 && ($urandom % 4) != 0) begin
                    rvalid = 1'b1;
                    r.id   = req_q[0].id;
                    r.data = (req_q[0].addr + 32'(4 * beat)) ^ (32'(s) << 28);
                    r.last = (beat == int'(req_q[0].len));
                end else begin
                    rvalid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run stalled with %0d bursts done after %0d cycles",
                     bursts, cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hba60));
        wait (!rst);
        for (int t = 0; t < 2; t++) begin
            err_before = errors;
            wait (g_mst[0].n_done >= (t + 1) * BURSTS_PER_TEST &&
                  g_mst[1].n_done >= (t + 1) * BURSTS_PER_TEST &&
                  g_mst[2].n_done >= (t + 1) * BURSTS_PER_TEST);
            repeat (2) @(posedge clk);
            $display("test %0d %s done: %0d bursts so far, %0d errors in this test",
                     t, (t == 0) ? "spread_slaves" : "contend_slave1", bursts,
                     errors - err_before);
        end
        $display("summary: %0d of 180 bursts, %0d errors, %0d cycles", bursts, errors, cycles);
        if (errors == 0 && bursts == 6 * BURSTS_PER_TEST) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: axi_read_xbar_top.f
+incdir+rtl
rtl/xbar_pkg.sv
rtl/xbar_skid_stage.sv
rtl/xbar_mst_switch.sv
rtl/xbar_slv_switch.sv
rtl/axi_read_xbar_top.sv
tests/tb_clock_gen.sv
tests/tb_scoreboard.sv
tests/xbar_checker.sv
tests/tb_axi_read_xbar.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f axi_read_xbar_top.f \
    --top-module tb_axi_read_xbar -o tb_sim > sim.log 2>&1 &&
./obj_dir/tb_sim >> sim.log 2>&1 || echo "simulation exited with a failing status" >> sim.log
cat sim.log
! grep -q "CHECKS FAILED" sim.log && ! grep -q "%Error" sim.log &&
grep -q "ALL CHECKS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
